// File: logic/gcu_pkg.sv
// widths, address map, scroll register numbers and RAM port operations
package gcu_pkg;

    // CPU and RAM word width
    parameter int DATA_W   = 16;
    parameter int VRAM_AW  = 13;
    parameter int LAYER_AW = 11;
    parameter int SCROLL_W = 13;

    // bit 7 of the register number is an alias bit
    parameter logic [7:0] REG_SEL_MASK = 8'h8F;

    // interrupt drops on this line
    parameter logic [8:0] VINT_LINE = 9'h0E6;

    // layer regions in main RAM address space
    parameter logic [VRAM_AW-1:0] SCROLL0_BASE = 13'h0000;
    parameter logic [VRAM_AW-1:0] SCROLL1_BASE = 13'h0800;
    parameter logic [VRAM_AW-1:0] SCROLL2_BASE = 13'h1000;
    parameter logic [VRAM_AW-1:0] SPRITE_BASE  = 13'h1800;
    parameter logic [VRAM_AW-1:0] SPRITE_END   = 13'h1C00;

    // register numbers with the alias bit removed
    typedef enum logic [7:0] {
        BG_X      = 8'h00,
        BG_Y      = 8'h01,
        FG_X      = 8'h02,
        FG_Y      = 8'h03,
        TXT_X     = 8'h04,
        TXT_Y     = 8'h05,
        SPR_X     = 8'h06,
        SPR_Y     = 8'h07,
        INT_ACK_A = 8'h0E,
        INT_ACK_B = 8'h0F
    } scroll_reg_e;

    typedef enum logic [2:0] {
        IDLE,
        SET_PTR,
        WRITE,
        READ_H,
        READ_L
    } vram_op_e;

endpackage

// File: logic/gcu_dpram.sv
// simple dual-port RAM, write port and registered read port
`timescale 1ns/1ps

module gcu_dpram #(
    parameter int AW = 11,
    parameter int DW = 16
) (
    input  logic          CLK96,
    input  logic [AW-1:0] wr_addr,
    input  logic [DW-1:0] wr_data,
    input  logic          wr_en,
    input  logic [AW-1:0] rd_addr,
    output logic [DW-1:0] rd_data
);

    logic [DW-1:0] mem [2**AW];

    always_ff @(posedge CLK96) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        // one cycle from address to data
        rd_data <= mem[rd_addr];
    end

endmodule

// File: logic/gcu_scroll_regs.sv
// register select latch and the eight layer scroll registers
`timescale 1ns/1ps

module gcu_scroll_regs (
    input  logic                                CLK96,
    input  logic                                RESET96,
    input  logic [gcu_pkg::DATA_W-1:0]          din,
    input  logic                                op_select_reg,
    input  logic                                op_write_reg,
    output gcu_pkg::scroll_reg_e                reg_sel,
    output logic signed [gcu_pkg::SCROLL_W-1:0] bg_scroll_x,
    output logic signed [gcu_pkg::SCROLL_W-1:0] bg_scroll_y,
    output logic signed [gcu_pkg::SCROLL_W-1:0] fg_scroll_x,
    output logic signed [gcu_pkg::SCROLL_W-1:0] fg_scroll_y,
    output logic signed [gcu_pkg::SCROLL_W-1:0] txt_scroll_x,
    output logic signed [gcu_pkg::SCROLL_W-1:0] txt_scroll_y,
    output logic signed [gcu_pkg::SCROLL_W-1:0] spr_scroll_x,
    output logic signed [gcu_pkg::SCROLL_W-1:0] spr_scroll_y
);

    // indexed by register number, x and y of each layer side by side
    logic [gcu_pkg::DATA_W-1:0] scroll_q [8];

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            // 0xFF selects nothing
            reg_sel <= gcu_pkg::scroll_reg_e'(8'hFF);
            for (int i = 0; i < 8; i++) begin
                scroll_q[i] <= '0;
            end
        end else if (op_select_reg) begin
            reg_sel <= gcu_pkg::scroll_reg_e'(din[7:0] & gcu_pkg::REG_SEL_MASK);
        end else if (op_write_reg) begin
            // alias bit ignored, unassigned numbers dropped
            case (gcu_pkg::scroll_reg_e'(reg_sel & 8'h7F))
                gcu_pkg::BG_X, gcu_pkg::BG_Y,
                gcu_pkg::FG_X, gcu_pkg::FG_Y,
                gcu_pkg::TXT_X, gcu_pkg::TXT_Y,
                gcu_pkg::SPR_X, gcu_pkg::SPR_Y: begin
                    scroll_q[reg_sel[2:0]] <= din;
                end
                default: begin
                end
            endcase
        end
    end

    // renderers only see the low bits
    assign bg_scroll_x  = scroll_q[0][gcu_pkg::SCROLL_W-1:0];
    assign bg_scroll_y  = scroll_q[1][gcu_pkg::SCROLL_W-1:0];
    assign fg_scroll_x  = scroll_q[2][gcu_pkg::SCROLL_W-1:0];
    assign fg_scroll_y  = scroll_q[3][gcu_pkg::SCROLL_W-1:0];
    assign txt_scroll_x = scroll_q[4][gcu_pkg::SCROLL_W-1:0];
    assign txt_scroll_y = scroll_q[5][gcu_pkg::SCROLL_W-1:0];
    assign spr_scroll_x = scroll_q[6][gcu_pkg::SCROLL_W-1:0];
    assign spr_scroll_y = scroll_q[7][gcu_pkg::SCROLL_W-1:0];

    // CPU never selects and writes in the same cycle
    a_one_reg_op: assert property (
        @(posedge CLK96) disable iff (RESET96)
        !(op_select_reg && op_write_reg)
    );

endmodule

// File: logic/gcu_vram_port.sv
// RAM pointer, write and read sequencing, ack and dout, main video RAM
`timescale 1ns/1ps

module gcu_vram_port #(
    parameter int VRAM_AW = 13
) (
    input  logic                       CLK96,
    input  logic                       RESET96,
    input  logic [gcu_pkg::DATA_W-1:0] din,
    input  logic                       op_set_ram_ptr,
    input  logic                       op_write_ram,
    input  logic                       op_read_ram_h,
    input  logic                       op_read_ram_l,
    output logic                       ack,
    output logic [gcu_pkg::DATA_W-1:0] dout,
    output logic [VRAM_AW-1:0]         vram_wr_addr,
    output logic [gcu_pkg::DATA_W-1:0] vram_wr_data,
    output logic                       vram_wr_en
);

    typedef enum logic [1:0] {
        SEQ_START,
        SEQ_BUSY,
        SEQ_DATA,
        SEQ_DONE
    } seq_e;

    gcu_pkg::vram_op_e          op;
    gcu_pkg::vram_op_e          last_op;
    seq_e                       seq;
    seq_e                       seq_cur;
    logic [VRAM_AW-1:0]         ram_ptr;
    logic [gcu_pkg::DATA_W-1:0] ram_q;
    logic                       rd_op;
    logic                       wr_start;
    logic                       wr_busy;
    logic                       rd_start;
    logic                       rd_load;

    always_comb begin
        if (op_set_ram_ptr) begin
            op = gcu_pkg::SET_PTR;
        end else if (op_write_ram) begin
            op = gcu_pkg::WRITE;
        end else if (op_read_ram_h) begin
            op = gcu_pkg::READ_H;
        end else if (op_read_ram_l) begin
            op = gcu_pkg::READ_L;
        end else begin
            op = gcu_pkg::IDLE;
        end
    end

    // new operation restarts the sequence
    assign seq_cur  = (op != last_op) ? SEQ_START : seq;
    assign rd_op    = (op == gcu_pkg::READ_H) || (op == gcu_pkg::READ_L);
    assign wr_start = (op == gcu_pkg::WRITE) && (seq_cur == SEQ_START);
    assign wr_busy  = (op == gcu_pkg::WRITE) && (seq_cur == SEQ_BUSY);
    assign rd_start = rd_op && (seq_cur == SEQ_START);
    assign rd_load  = rd_op && (seq_cur == SEQ_DATA);

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            last_op    <= gcu_pkg::IDLE;
            seq        <= SEQ_START;
            ack        <= 1'b1;
            vram_wr_en <= 1'b0;
            ram_ptr    <= '0;
        end else begin
            last_op    <= op;
            vram_wr_en <= wr_start;
            // low from the first edge until the word is written or loaded
            ack <= !(wr_start || rd_start || (rd_op && seq_cur == SEQ_BUSY));
            if (op == gcu_pkg::SET_PTR) begin
                ram_ptr <= din[VRAM_AW-1:0];
            end else if (wr_busy) begin
                ram_ptr <= ram_ptr + VRAM_AW'(1);
            end
            case (seq_cur)
                SEQ_START: seq <= (wr_start || rd_start) ? SEQ_BUSY : SEQ_START;
                SEQ_BUSY:  seq <= rd_op ? SEQ_DATA : SEQ_DONE;
                default:   seq <= SEQ_DONE;
            endcase
        end
    end

    // address, write word and read result
    always_ff @(posedge CLK96) begin
        if (wr_start) begin
            vram_wr_addr <= ram_ptr;
            vram_wr_data <= din;
        end else if (rd_start) begin
            vram_wr_addr <= ram_ptr + VRAM_AW'(op == gcu_pkg::READ_L);
        end
        if (rd_load) begin
            dout <= ram_q;
        end
    end

    gcu_dpram #(
        .AW(VRAM_AW),
        .DW(gcu_pkg::DATA_W)
    ) u_main_ram (
        .CLK96  (CLK96),
        .wr_addr(vram_wr_addr),
        .wr_data(vram_wr_data),
        .wr_en  (vram_wr_en),
        .rd_addr(vram_wr_addr),
        .rd_data(ram_q)
    );

    a_wr_en_pulse: assert property (
        @(posedge CLK96) disable iff (RESET96)
        vram_wr_en |=> !vram_wr_en
    );

    // an idle cycle always leaves the port ready
    a_ack_when_idle: assert property (
        @(posedge CLK96) disable iff (RESET96)
        !(op_set_ram_ptr || op_write_ram || op_read_ram_h || op_read_ram_l) |=> ack
    );

endmodule

// File: logic/gcu_layer_rams.sv
// write decode into the four layer mirror RAMs with renderer read ports
`timescale 1ns/1ps

module gcu_layer_rams #(
    parameter int LAYER_AW = 11
) (
    input  logic                        CLK96,
    input  logic [gcu_pkg::VRAM_AW-1:0] vram_wr_addr,
    input  logic [gcu_pkg::DATA_W-1:0]  vram_wr_data,
    input  logic                        vram_wr_en,
    input  logic [LAYER_AW-1:0]         scr0_addr,
    input  logic [LAYER_AW-1:0]         scr1_addr,
    input  logic [LAYER_AW-1:0]         scr2_addr,
    input  logic [LAYER_AW-1:0]         spr_addr,
    output logic [gcu_pkg::DATA_W-1:0]  scr0_data,
    output logic [gcu_pkg::DATA_W-1:0]  scr1_data,
    output logic [gcu_pkg::DATA_W-1:0]  scr2_data,
    output logic [gcu_pkg::DATA_W-1:0]  spr_data
);

    // region i spans bound[i] up to bound[i+1]
    localparam logic [gcu_pkg::VRAM_AW-1:0] BOUND [5] = '{
        gcu_pkg::SCROLL0_BASE,
        gcu_pkg::SCROLL1_BASE,
        gcu_pkg::SCROLL2_BASE,
        gcu_pkg::SPRITE_BASE,
        gcu_pkg::SPRITE_END
    };

    logic [LAYER_AW-1:0]        rd_addr [4];
    logic [gcu_pkg::DATA_W-1:0] rd_data [4];
    logic [3:0]                 hit;

    assign rd_addr[0] = scr0_addr;
    assign rd_addr[1] = scr1_addr;
    assign rd_addr[2] = scr2_addr;
    assign rd_addr[3] = spr_addr;

    for (genvar i = 0; i < 4; i++) begin : g_layer
        // offset from the base wraps high when below it
        assign hit[i] = vram_wr_en &&
                        ((vram_wr_addr - BOUND[i]) < (BOUND[i+1] - BOUND[i]));

        gcu_dpram #(
            .AW(LAYER_AW),
            .DW(gcu_pkg::DATA_W)
        ) u_mirror (
            .CLK96  (CLK96),
            .wr_addr(vram_wr_addr[LAYER_AW-1:0]),
            .wr_data(vram_wr_data),
            .wr_en  (hit[i]),
            .rd_addr(rd_addr[i]),
            .rd_data(rd_data[i])
        );
    end

    assign scr0_data = rd_data[0];
    assign scr1_data = rd_data[1];
    assign scr2_data = rd_data[2];
    assign spr_data  = rd_data[3];

endmodule

// File: logic/gcu_video_timing.sv
// sync and blank levels and the vertical interrupt
`timescale 1ns/1ps

module gcu_video_timing (
    input  logic                 RESET96,
    input  logic [8:0]           h,
    input  logic [8:0]           v,
    input  logic [8:0]           hs_start,
    input  logic [8:0]           hs_end,
    input  logic [8:0]           vs_start,
    input  logic [8:0]           vs_end,
    input  gcu_pkg::scroll_reg_e reg_sel,
    output logic                 hsync,
    output logic                 vsync,
    output logic                 fblank,
    output logic                 vint
);

    logic int_ack;

    // hsync bounds exclusive, vsync bounds inclusive
    assign hsync  = !((h > hs_start) && (h < hs_end));
    assign vsync  = !((v >= vs_start) && (v <= vs_end));
    assign fblank = hsync && vsync;

    // selecting an ack register holds the interrupt line low
    assign int_ack = (reg_sel == gcu_pkg::INT_ACK_A) ||
                     (reg_sel == gcu_pkg::INT_ACK_B) ||
                     (reg_sel == (gcu_pkg::INT_ACK_B | 8'h80));

    assign vint = !(RESET96 || (v == gcu_pkg::VINT_LINE) || int_ack);

endmodule

// File: logic/gcu_vdp.sv
// video controller CPU side: scroll registers, RAM port, layer mirrors, timing
`timescale 1ns/1ps

module gcu_vdp (
    input  logic                                 CLK96,
    input  logic                                 RESET96,
    input  logic [gcu_pkg::DATA_W-1:0]           din,
    input  logic                                 op_select_reg,
    input  logic                                 op_write_reg,
    input  logic                                 op_set_ram_ptr,
    input  logic                                 op_write_ram,
    input  logic                                 op_read_ram_h,
    input  logic                                 op_read_ram_l,
    output logic                                 ack,
    output logic [gcu_pkg::DATA_W-1:0]           dout,
    input  logic [8:0]                           h,
    input  logic [8:0]                           v,
    input  logic [8:0]                           hs_start,
    input  logic [8:0]                           hs_end,
    input  logic [8:0]                           vs_start,
    input  logic [8:0]                           vs_end,
    output logic                                 hsync,
    output logic                                 vsync,
    output logic                                 fblank,
    output logic                                 vint,
    output logic signed [gcu_pkg::SCROLL_W-1:0]  bg_scroll_x,
    output logic signed [gcu_pkg::SCROLL_W-1:0]  bg_scroll_y,
    output logic signed [gcu_pkg::SCROLL_W-1:0]  fg_scroll_x,
    output logic signed [gcu_pkg::SCROLL_W-1:0]  fg_scroll_y,
    output logic signed [gcu_pkg::SCROLL_W-1:0]  txt_scroll_x,
    output logic signed [gcu_pkg::SCROLL_W-1:0]  txt_scroll_y,
    output logic signed [gcu_pkg::SCROLL_W-1:0]  spr_scroll_x,
    output logic signed [gcu_pkg::SCROLL_W-1:0]  spr_scroll_y,
    input  logic [gcu_pkg::LAYER_AW-1:0]         scr0_addr,
    input  logic [gcu_pkg::LAYER_AW-1:0]         scr1_addr,
    input  logic [gcu_pkg::LAYER_AW-1:0]         scr2_addr,
    input  logic [gcu_pkg::LAYER_AW-1:0]         spr_addr,
    output logic [gcu_pkg::DATA_W-1:0]           scr0_data,
    output logic [gcu_pkg::DATA_W-1:0]           scr1_data,
    output logic [gcu_pkg::DATA_W-1:0]           scr2_data,
    output logic [gcu_pkg::DATA_W-1:0]           spr_data
);

    gcu_pkg::scroll_reg_e        reg_sel;
    logic [gcu_pkg::VRAM_AW-1:0] vram_wr_addr;
    logic [gcu_pkg::DATA_W-1:0]  vram_wr_data;
    logic                        vram_wr_en;

    gcu_scroll_regs u_scroll_regs (
        .CLK96        (CLK96),
        .RESET96      (RESET96),
        .din          (din),
        .op_select_reg(op_select_reg),
        .op_write_reg (op_write_reg),
        .reg_sel      (reg_sel),
        .bg_scroll_x  (bg_scroll_x),
        .bg_scroll_y  (bg_scroll_y),
        .fg_scroll_x  (fg_scroll_x),
        .fg_scroll_y  (fg_scroll_y),
        .txt_scroll_x (txt_scroll_x),
        .txt_scroll_y (txt_scroll_y),
        .spr_scroll_x (spr_scroll_x),
        .spr_scroll_y (spr_scroll_y)
    );

    gcu_vram_port #(
        .VRAM_AW(gcu_pkg::VRAM_AW)
    ) u_vram_port (
        .CLK96         (CLK96),
        .RESET96       (RESET96),
        .din           (din),
        .op_set_ram_ptr(op_set_ram_ptr),
        .op_write_ram  (op_write_ram),
        .op_read_ram_h (op_read_ram_h),
        .op_read_ram_l (op_read_ram_l),
        .ack           (ack),
        .dout          (dout),
        .vram_wr_addr  (vram_wr_addr),
        .vram_wr_data  (vram_wr_data),
        .vram_wr_en    (vram_wr_en)
    );

    gcu_layer_rams #(
        .LAYER_AW(gcu_pkg::LAYER_AW)
    ) u_layer_rams (
        .CLK96       (CLK96),
        .vram_wr_addr(vram_wr_addr),
        .vram_wr_data(vram_wr_data),
        .vram_wr_en  (vram_wr_en),
        .scr0_addr   (scr0_addr),
        .scr1_addr   (scr1_addr),
        .scr2_addr   (scr2_addr),
        .spr_addr    (spr_addr),
        .scr0_data   (scr0_data),
        .scr1_data   (scr1_data),
        .scr2_data   (scr2_data),
        .spr_data    (spr_data)
    );

    gcu_video_timing u_video_timing (
        .RESET96 (RESET96),
        .h       (h),
        .v       (v),
        .hs_start(hs_start),
        .hs_end  (hs_end),
        .vs_start(vs_start),
        .vs_end  (vs_end),
        .reg_sel (reg_sel),
        .hsync   (hsync),
        .vsync   (vsync),
        .fblank  (fblank),
        .vint    (vint)
    );

endmodule

// File: sim/tb_gcu_vdp.sv
// testbench for the video controller CPU side: clock, reset, directed tests, watchdog
`timescale 1ns/1ps

module tb_gcu_vdp;

    localparam int CLK_PERIOD = 4;

    // cycles per test, roughly as the tasks below spend them
    localparam int RESET_CYCLES  = 12;
    localparam int SCROLL_CYCLES = 10 * 4;
    localparam int RAM_CYCLES    = 2 + 32 * 3 + 32 * 6;
    localparam int RDLOW_CYCLES  = 10;
    localparam int LAYER_CYCLES  = 5 * 5 + 2;
    localparam int SYNC_CYCLES   = 48 * 24 + 10;
    localparam int TOTAL_CYCLES  = RESET_CYCLES + SCROLL_CYCLES + RAM_CYCLES + RDLOW_CYCLES
                                   + LAYER_CYCLES + SYNC_CYCLES + 500;

    logic                                CLK96;
    logic                                RESET96;
    logic [gcu_pkg::DATA_W-1:0]          din;
    logic                                op_select_reg;
    logic                                op_write_reg;
    logic                                op_set_ram_ptr;
    logic                                op_write_ram;
    logic                                op_read_ram_h;
    logic                                op_read_ram_l;
    logic                                ack;
    logic [gcu_pkg::DATA_W-1:0]          dout;
    logic [8:0]                          h;
    logic [8:0]                          v;
    logic [8:0]                          hs_start;
    logic [8:0]                          hs_end;
    logic [8:0]                          vs_start;
    logic [8:0]                          vs_end;
    logic                                hsync;
    logic                                vsync;
    logic                                fblank;
    logic                                vint;
    logic signed [gcu_pkg::SCROLL_W-1:0] bg_scroll_x;
    logic signed [gcu_pkg::SCROLL_W-1:0] bg_scroll_y;
    logic signed [gcu_pkg::SCROLL_W-1:0] fg_scroll_x;
    logic signed [gcu_pkg::SCROLL_W-1:0] fg_scroll_y;
    logic signed [gcu_pkg::SCROLL_W-1:0] txt_scroll_x;
    logic signed [gcu_pkg::SCROLL_W-1:0] txt_scroll_y;
    logic signed [gcu_pkg::SCROLL_W-1:0] spr_scroll_x;
    logic signed [gcu_pkg::SCROLL_W-1:0] spr_scroll_y;
    logic [gcu_pkg::LAYER_AW-1:0]        scr0_addr;
    logic [gcu_pkg::LAYER_AW-1:0]        scr1_addr;
    logic [gcu_pkg::LAYER_AW-1:0]        scr2_addr;
    logic [gcu_pkg::LAYER_AW-1:0]        spr_addr;
    logic [gcu_pkg::DATA_W-1:0]          scr0_data;
    logic [gcu_pkg::DATA_W-1:0]          scr1_data;
    logic [gcu_pkg::DATA_W-1:0]          scr2_data;
    logic [gcu_pkg::DATA_W-1:0]          spr_data;

    logic [31:0] rng_state;
    // expected main RAM contents
    logic [15:0] model [8192];
    int          errors;

    gcu_vdp uut (.*);

    always #(CLK_PERIOD / 2) CLK96 = ~CLK96;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [15:0] rand_word();
        rng_state = lcg_next(rng_state);
        return rng_state[31:16];
    endfunction

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge CLK96);
        #1;
    endtask

    task automatic set_strobe(input gcu_pkg::vram_op_e op, input logic level);
        case (op)
            gcu_pkg::SET_PTR: op_set_ram_ptr = level;
            gcu_pkg::WRITE:   op_write_ram = level;
            gcu_pkg::READ_H:  op_read_ram_h = level;
            gcu_pkg::READ_L:  op_read_ram_l = level;
            default: begin
            end
        endcase
    endtask

    // strobe held until ack is back, then one idle cycle
    task automatic ram_cmd(input gcu_pkg::vram_op_e op, input logic [15:0] data,
                           output int low_cycles);
        low_cycles = 0;
        din = data;
        set_strobe(op, 1'b1);
        next_cycle();
        if (op != gcu_pkg::SET_PTR) begin
            while (!ack) begin
                low_cycles++;
                next_cycle();
            end
        end
        set_strobe(op, 1'b0);
        next_cycle();
    endtask

    task automatic select_reg(input logic [7:0] num);
        din = {8'h00, num};
        op_select_reg = 1'b1;
        next_cycle();
        op_select_reg = 1'b0;
        next_cycle();
    endtask

    task automatic write_reg(input logic [15:0] value);
        din = value;
        op_write_reg = 1'b1;
        next_cycle();
        op_write_reg = 1'b0;
        next_cycle();
    endtask

    function automatic logic [12:0] scroll_out(input int idx);
        case (idx)
            0: return bg_scroll_x;
            1: return bg_scroll_y;
            2: return fg_scroll_x;
            3: return fg_scroll_y;
            4: return txt_scroll_x;
            5: return txt_scroll_y;
            6: return spr_scroll_x;
            default: return spr_scroll_y;
        endcase
    endfunction

    task automatic scroll_regs_test();
        logic [12:0] expected [8];
        logic [15:0] value;
        for (int i = 0; i < 8; i++) begin
            value = rand_word();
            // odd numbers go through the alias bit
            select_reg(8'(i) | ((i % 2 == 1) ? 8'h80 : 8'h00));
            write_reg(value);
            expected[i] = value[12:0];
        end
        for (int i = 0; i < 8; i++) begin
            if (scroll_out(i) !== expected[i]) begin
                errors++;
                $display("[ERROR] %0t: scroll register %0d is %h, expected %h",
                         $time, i, scroll_out(i), expected[i]);
            end
        end
        // 0x09 is not a scroll register
        select_reg(8'h09);
        write_reg(rand_word());
        for (int i = 0; i < 8; i++) begin
            if (scroll_out(i) !== expected[i]) begin
                errors++;
                $display("[ERROR] %0t: scroll register %0d is %h after write to 0x09, expected %h",
                         $time, i, scroll_out(i), expected[i]);
            end
        end
    endtask

    task automatic ram_readback_test();
        logic [12:0] base;
        logic [12:0] addr;
        logic [15:0] value;
        int          low;
        base = 13'h0123;
        ram_cmd(gcu_pkg::SET_PTR, 16'(base), low);
        for (int i = 0; i < 32; i++) begin
            addr = base + 13'(i);
            value = rand_word();
            model[addr] = value;
            ram_cmd(gcu_pkg::WRITE, value, low);
            if (low != 1) begin
                errors++;
                $display("[ERROR] %0t: write to %h held ack low %0d cycles, expected 1",
                         $time, addr, low);
            end
        end
        // reads leave the pointer alone, so it is set for each word
        for (int i = 0; i < 32; i++) begin
            addr = base + 13'(i);
            ram_cmd(gcu_pkg::SET_PTR, 16'(addr), low);
            ram_cmd(gcu_pkg::READ_H, 16'h0000, low);
            if (dout !== model[addr]) begin
                errors++;
                $display("[ERROR] %0t: read at %h gave %h, expected %h",
                         $time, addr, dout, model[addr]);
            end
            if (low != 2) begin
                errors++;
                $display("[ERROR] %0t: read at %h held ack low %0d cycles, expected 2",
                         $time, addr, low);
            end
        end
    endtask

    task automatic read_low_test();
        logic [12:0] addr;
        int          low;
        addr = 13'h012A;
        ram_cmd(gcu_pkg::SET_PTR, 16'(addr), low);
        ram_cmd(gcu_pkg::READ_L, 16'h0000, low);
        if (dout !== model[addr + 13'd1]) begin
            errors++;
            $display("[ERROR] %0t: read-low at %h gave %h, expected %h",
                     $time, addr, dout, model[addr + 13'd1]);
        end
        ram_cmd(gcu_pkg::READ_H, 16'h0000, low);
        if (dout !== model[addr]) begin
            errors++;
            $display("[ERROR] %0t: read-high after read-low gave %h, expected %h",
                     $time, dout, model[addr]);
        end
    endtask

    task automatic layer_mirror_test();
        logic [12:0] addr [5];
        logic [15:0] value [5];
        int          low;
        // last one lies above the sprite region, same offset as the third
        addr = '{13'h0010, 13'h0823, 13'h1456, 13'h18A9, 13'h1C56};
        for (int i = 0; i < 5; i++) begin
            value[i] = rand_word();
            model[addr[i]] = value[i];
            ram_cmd(gcu_pkg::SET_PTR, 16'(addr[i]), low);
            ram_cmd(gcu_pkg::WRITE, value[i], low);
        end
        scr0_addr = addr[0][10:0];
        scr1_addr = addr[1][10:0];
        scr2_addr = addr[2][10:0];
        spr_addr = addr[3][10:0];
        next_cycle();
        if (scr0_data !== value[0] || scr1_data !== value[1] ||
            scr2_data !== value[2] || spr_data !== value[3]) begin
            errors++;
            $display("[ERROR] %0t: layer data %h %h %h %h, expected %h %h %h %h", $time,
                     scr0_data, scr1_data, scr2_data, spr_data,
                     value[0], value[1], value[2], value[3]);
        end
        spr_addr = addr[4][10:0];
        next_cycle();
        if (scr2_data !== value[2] || spr_data === value[4]) begin
            errors++;
            $display("[ERROR] %0t: write above sprite region reached a mirror", $time);
        end
    endtask

    task automatic sync_interrupt_test();
        logic       exp_h;
        logic       exp_v;
        logic [7:0] ack_regs [3];
        hs_start = 9'd20;
        hs_end = 9'd40;
        vs_start = 9'd10;
        vs_end = 9'd15;
        for (int j = 0; j < 24; j++) begin
            for (int i = 0; i < 48; i++) begin
                next_cycle();
                h = 9'(i);
                v = 9'(j);
                #1;
                // high on the horizontal bounds themselves, low only on the lines between
                exp_h = (i <= int'(hs_start)) || (i >= int'(hs_end));
                exp_v = (j < int'(vs_start)) || (j > int'(vs_end));
                if (hsync !== exp_h || vsync !== exp_v || fblank !== (exp_h && exp_v)) begin
                    errors++;
                    $display("[ERROR] %0t: h %0d v %0d gave sync %b%b%b, expected %b%b%b",
                             $time, h, v, hsync, vsync, fblank, exp_h, exp_v, exp_h && exp_v);
                end
            end
        end
        v = 9'd100;
        #1;
        if (vint !== 1'b1) begin
            errors++;
            $display("[ERROR] %0t: vint is %b with no interrupt condition", $time, vint);
        end
        v = 9'h0E6;
        #1;
        if (vint !== 1'b0) begin
            errors++;
            $display("[ERROR] %0t: vint is %b on line 0xE6, expected 0", $time, vint);
        end
        v = 9'd100;
        ack_regs = '{8'h0F, 8'h8F, 8'h0E};
        for (int k = 0; k < 3; k++) begin
            select_reg(ack_regs[k]);
            if (vint !== 1'b0) begin
                errors++;
                $display("[ERROR] %0t: vint is %b after selecting %h, expected 0",
                         $time, vint, ack_regs[k]);
            end
        end
        select_reg(8'h00);
        if (vint !== 1'b1) begin
            errors++;
            $display("[ERROR] %0t: vint is %b after selecting 00, expected 1", $time, vint);
        end
    endtask

    initial begin
        CLK96 = 1'b0;
        RESET96 = 1'b1;
        din = '0;
        op_select_reg = 1'b0;
        op_write_reg = 1'b0;
        op_set_ram_ptr = 1'b0;
        op_write_ram = 1'b0;
        op_read_ram_h = 1'b0;
        op_read_ram_l = 1'b0;
        h = '0;
        v = '0;
        hs_start = '0;
        hs_end = '0;
        vs_start = '0;
        vs_end = '0;
        scr0_addr = '0;
        scr1_addr = '0;
        scr2_addr = '0;
        spr_addr = '0;
        errors = 0;
        rng_state = 32'h6f3cd40e;
        repeat (10) @(posedge CLK96);
        #1;
        if (vint !== 1'b0) begin
            errors++;
            $display("[ERROR] %0t: vint is %b during reset, expected 0", $time, vint);
        end
        RESET96 = 1'b0;
        next_cycle();
        if (ack !== 1'b1) begin
            errors++;
            $display("[ERROR] %0t: ack is %b after reset, expected 1", $time, ack);
        end
        scroll_regs_test();
        ram_readback_test();
        read_low_test();
        layer_mirror_test();
        sync_interrupt_test();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #(TOTAL_CYCLES * CLK_PERIOD);
        $display("watchdog expired, the tests did not finish within %0d cycles", TOTAL_CYCLES);
        $display("test failed");
        $finish;
    end

endmodule

// File: gcu_vdp.f
logic/gcu_pkg.sv
logic/gcu_dpram.sv
logic/gcu_scroll_regs.sv
logic/gcu_vram_port.sv
logic/gcu_layer_rams.sv
logic/gcu_video_timing.sv
logic/gcu_vdp.sv
sim/tb_gcu_vdp.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_gcu_vdp \
    -f gcu_vdp.f -Mdir obj_dir -o tb_gcu_vdp > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "compile failed"
    exit 1
fi

./obj_dir/tb_gcu_vdp > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "test failed" sim.log; then
    exit 1
fi
exit 0
